// File: io_top.f
src/io_pkg.sv
src/io_controller.sv
src/tx_fifo.sv
src/uart_tx.sv
src/interval_timer.sv
src/seg_decoder.sv
src/io_top.sv
tb/io_top_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# Exits non-zero unless the simulation prints the pass message.
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
    --top-module io_top_tb -f io_top.f -o io_top_sim; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/io_top_sim)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

// File: tb/io_top_tb.sv
module io_top_tb
  import io_pkg::*;
();

  logic        clk;
  logic        rst;
  logic        cyc;
  logic        stb;
  logic        we;
  addr_t       adr;
  word_t       wdat;
  logic [15:0] sw;
  word_t       rdat;
  logic        ack;
  logic [8:0]  led;
  logic        tx;
  logic        irq;
  hex_t [7:0]  hex;

  logic [31:0] lfsr;
  int          errors;
  int          tests_failed;
  logic        busy;              // bus cycle in flight so the model may lag
  logic [8:0]  exp_led;
  word_t       exp_seg;
  byte_t       rx_q[$];           // bytes seen on the line
  byte_t       exp_q[$];

  io_top uut (
    .clk_i(clk), .rst_i(rst), .cyc_i(cyc), .stb_i(stb), .we_i(we),
    .adr_i(adr), .dat_i(wdat), .sw_i(sw),
    .dat_o(rdat), .ack_o(ack), .led_o(led), .tx_o(tx), .irq_o(irq), .hex_o(hex)
  );

  always #10 clk = ~clk;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < nbits; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // lit segments in gfedcba order
  function automatic logic [6:0] lit_segments(input logic [3:0] nib);
    case (nib)
      4'h0:    return 7'h3f;
      4'h1:    return 7'h06;
      4'h2:    return 7'h5b;
      4'h3:    return 7'h4f;
      4'h4:    return 7'h66;
      4'h5:    return 7'h6d;
      4'h6:    return 7'h7d;
      4'h7:    return 7'h07;
      4'h8:    return 7'h7f;
      4'h9:    return 7'h6f;
      4'ha:    return 7'h77;
      4'hb:    return 7'h7c;
      4'hc:    return 7'h39;
      4'hd:    return 7'h5e;
      4'he:    return 7'h79;
      default: return 7'h71;
    endcase
  endfunction

  function automatic logic [55:0] expected_digits(input word_t w);
    logic [55:0] d;
    for (int i = 0; i < 8; i++)
      d[7*i +: 7] = ~lit_segments(w[4*i +: 4]);  // display is active low
    return d;
  endfunction

  function automatic addr_t reg_addr(input region_t r, input logic [1:0] off);
    return {r, 8'h00, off};
  endfunction

  reset_state: assert property (@(posedge clk) $fell(rst) |->
      (!ack && led == 9'h0 && !irq && tx && hex == expected_digits(32'h0)))
    else
    begin
      errors++;
      $display("MISMATCH at %0t: outputs not in reset state after reset", $time);
    end

  led_model: assert property (@(posedge clk) disable iff (rst || busy) led == exp_led)
    else
    begin
      errors++;
      $display("MISMATCH at %0t: led_o %h, expected %h", $time, led, exp_led);
    end

  hex_model: assert property (@(posedge clk) disable iff (rst || busy)
      hex == expected_digits(exp_seg))
    else
    begin
      errors++;
      $display("MISMATCH at %0t: hex_o wrong for display word %h", $time, exp_seg);
    end

  task automatic bus_access(input logic wr, input addr_t a, input word_t d,
                            output word_t q);
    int n;
    n = 0;
    q = '0;
    @(posedge clk);
    #2;
    busy = 1'b1;
    cyc  = 1'b1;
    stb  = 1'b1;
    we   = wr;
    adr  = a;
    wdat = d;
    do
    begin
      @(posedge clk);
      #1;
      n++;
    end
    while (!ack && n < 16);
    if (!ack)
    begin
      errors++;
      $display("no ack within 16 cycles for address %h", a);
    end
    else
    begin
      q = rdat;
      if (n != 2)
      begin
        errors++;
        $display("ack came %0d cycles after the request edge instead of 2", n);
      end
    end
    @(posedge clk);
    #2;
    cyc  = 1'b0;
    stb  = 1'b0;
    we   = 1'b0;
    busy = 1'b0;
  endtask

  task automatic bus_write(input addr_t a, input word_t d);
    word_t discard;
    bus_access(1'b1, a, d, discard);
    if (a[13:10] == REG_SWLED)
      exp_led = d[8:0];
    else if (a[13:10] == REG_SEG)
      exp_seg = d;
  endtask

  task automatic bus_read(input addr_t a, input logic check, input word_t expv,
                          output word_t q);
    bus_access(1'b0, a, '0, q);
    if (check)
      assert (q === expv)
      else
      begin
        errors++;
        $display("MISMATCH at %0t: read %h at address %h, expected %h", $time, q, a, expv);
      end
  endtask

  // waits for every expected byte and then expects an empty fifo
  task automatic check_uart_bytes(input int lim);
    int    n;
    word_t st;
    byte_t got;
    byte_t want;
    n = 0;
    while (rx_q.size() < exp_q.size() && n < lim)
    begin
      @(posedge clk);
      #1;
      n++;
    end
    if (rx_q.size() < exp_q.size())
    begin
      errors++;
      $display("timeout with %0d of %0d uart bytes received", rx_q.size(), exp_q.size());
    end
    bus_read(reg_addr(REG_UART, 2'd0), 1'b1, 32'h100, st);
    while (exp_q.size() > 0 && rx_q.size() > 0)
    begin
      want = exp_q.pop_front();
      got  = rx_q.pop_front();
      assert (got == want)
      else
      begin
        errors++;
        $display("MISMATCH at %0t: uart byte %h, expected %h", $time, got, want);
      end
    end
    exp_q.delete();
    rx_q.delete();
  endtask

  task automatic report_test(input string name, input int base);
    if (errors == base)
      $display("%s: ok", name);
    else
    begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", name, errors - base);
    end
  endtask

  // samples each bit in its middle
  initial
  begin : uart_monitor
    byte_t b;
    forever
    begin
      @(posedge clk);
      #1;
      if (!rst && !tx)
      begin
        repeat (CLKS_PER_BIT / 2) @(posedge clk);
        #1;
        assert (!tx)
        else
        begin
          errors++;
          $display("MISMATCH at %0t: start bit not low in its middle", $time);
        end
        for (int i = 0; i < 8; i++)
        begin
          repeat (CLKS_PER_BIT) @(posedge clk);
          #1;
          b[i] = tx;  // lsb first
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        #1;
        assert (tx)
        else
        begin
          errors++;
          $display("MISMATCH at %0t: stop bit low", $time);
        end
        rx_q.push_back(b);
      end
    end
  end

  initial
  begin : main
    word_t st;
    byte_t b;
    int    base;
    int    n;
    int    lim;
    int    fill;
    logic  saw_full;
    clk          = 1'b0;
    rst          = 1'b1;
    cyc          = 1'b0;
    stb          = 1'b0;
    we           = 1'b0;
    adr          = '0;
    wdat         = '0;
    busy         = 1'b0;
    errors       = 0;
    tests_failed = 0;
    exp_led      = '0;
    exp_seg      = '0;
    lfsr         = 32'h6c6e;
    sw           = 16'(rand_bits(16));
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    base = 0;
    bus_write(reg_addr(REG_SWLED, 2'd0), rand_bits(9));
    bus_write(reg_addr(REG_SWLED, 2'd0), rand_bits(32));  // upper bits ignored
    bus_read(reg_addr(REG_SWLED, 2'd0), 1'b1, {16'h0000, sw}, st);
    report_test("reset, switches and leds", base);

    base = errors;
    bus_write(reg_addr(REG_SEG, 2'd0), rand_bits(32));
    bus_read(reg_addr(REG_SEG, 2'd0), 1'b1, exp_seg, st);
    bus_write(reg_addr(REG_SEG, 2'd0), rand_bits(32));
    bus_read(reg_addr(REG_SEG, 2'd0), 1'b1, exp_seg, st);
    report_test("display", base);

    base = errors;
    for (int i = 0; i < 5; i++)
    begin
      b = 8'(rand_bits(8));
      exp_q.push_back(b);
      bus_write(reg_addr(REG_UART, 2'd0), {24'(rand_bits(24)), b});
    end
    check_uart_bytes(90 * 5 + 100);
    report_test("uart order", base);

    // status before each write tells whether the byte is kept
    base     = errors;
    saw_full = 1'b0;
    for (int i = 0; i < 10; i++)
    begin
      b    = 8'(rand_bits(8));
      fill = (exp_q.size() > 0) ? exp_q.size() - 1 : 0;  // uart took the first byte
      bus_read(reg_addr(REG_UART, 2'd0), 1'b1,
               {22'h0, (fill == FIFO_DEPTH), (fill == 0), 4'h0, 4'(fill)}, st);
      if (st[9])
        saw_full = 1'b1;
      else
        exp_q.push_back(b);
      bus_write(reg_addr(REG_UART, 2'd0), {24'h000000, b});
    end
    assert (saw_full)
    else
    begin
      errors++;
      $display("fifo status never showed the full flag");
    end
    check_uart_bytes(90 * 10 + 100);
    report_test("fifo full", base);

    base = errors;
    lim  = 8 + int'(rand_bits(5));
    bus_write(reg_addr(REG_TIMER, 2'd0), word_t'(lim));
    bus_read(reg_addr(REG_TIMER, 2'd0), 1'b1, word_t'(lim), st);
    bus_write(reg_addr(REG_TIMER, 2'd2), 32'h1);
    n = 0;
    while (!irq && n < lim + 2)
    begin
      @(posedge clk);
      #1;
      n++;
    end
    assert (irq)
    else
    begin
      errors++;
      $display("irq did not rise within %0d cycles", lim + 2);
    end
    bus_read(reg_addr(REG_TIMER, 2'd2), 1'b1, 32'h3, st);
    bus_write(reg_addr(REG_TIMER, 2'd2), 32'h2);  // disable and clear
    assert (!irq)
    else
    begin
      errors++;
      $display("MISMATCH at %0t: irq still high after clear", $time);
    end
    bus_read(reg_addr(REG_TIMER, 2'd2), 1'b1, 32'h0, st);
    report_test("timer", base);

    base = errors;
    bus_read(reg_addr(4'd9, 2'd0), 1'b1, 32'h0, st);
    bus_write(reg_addr(4'd9, 2'd0), rand_bits(32));
    bus_read(reg_addr(REG_SEG, 2'd0), 1'b1, exp_seg, st);
    bus_read(reg_addr(4'd9, 2'd1), 1'b1, 32'h0, st);
    report_test("unmapped region", base);

    $display("tests run: 6, tests failed: %0d, errors: %0d", tests_failed, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// File: src/io_top.sv
module io_top
  import io_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  addr_t       adr_i,
  input  word_t       dat_i,
  input  logic [15:0] sw_i,
  output word_t       dat_o,
  output logic        ack_o,
  output logic [8:0]  led_o,
  output logic        tx_o,
  output logic        irq_o,
  output hex_t [7:0]  hex_o
);

  word_t uart_dat, timer_dat, seg_word;
  logic  uart_stb, uart_ack, timer_stb, timer_ack;
  byte_t fifo_head;
  logic  fifo_empty, fifo_pop;

  io_controller ctrl0 (
    .clk_i(clk_i), .rst_i(rst_i),
    .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i), .adr_i(adr_i), .dat_i(dat_i),
    .sw_i(sw_i),
    .uart_dat_i(uart_dat), .uart_ack_i(uart_ack),
    .timer_dat_i(timer_dat), .timer_ack_i(timer_ack),
    .dat_o(dat_o), .ack_o(ack_o),
    .uart_stb_o(uart_stb), .timer_stb_o(timer_stb),
    .led_o(led_o), .seg_o(seg_word)
  );

  tx_fifo fifo0 (
    .clk_i(clk_i), .rst_i(rst_i),
    .stb_i(uart_stb), .we_i(we_i), .dat_i(dat_i), .pop_i(fifo_pop),
    .dat_o(uart_dat), .ack_o(uart_ack), .head_o(fifo_head), .empty_o(fifo_empty)
  );

  uart_tx uart0 (
    .clk_i(clk_i), .rst_i(rst_i),
    .head_i(fifo_head), .empty_i(fifo_empty),
    .pop_o(fifo_pop), .tx_o(tx_o)
  );

  interval_timer timer0 (
    .clk_i(clk_i), .rst_i(rst_i),
    .stb_i(timer_stb), .we_i(we_i), .adr_i(adr_i[1:0]), .dat_i(dat_i),
    .dat_o(timer_dat), .ack_o(timer_ack), .irq_o(irq_o)
  );

  seg_decoder seg0 (.seg_i(seg_word), .hex_o(hex_o));

endmodule

// File: src/seg_decoder.sv
module seg_decoder
  import io_pkg::*;
(
  input  word_t      seg_i,
  output hex_t [7:0] hex_o
);

  // gfedcba, low lights the segment
  function automatic hex_t nib_to_seg(input logic [3:0] nib);
    case (nib)
      4'h0:    return 7'h40;
      4'h1:    return 7'h79;
      4'h2:    return 7'h24;
      4'h3:    return 7'h30;
      4'h4:    return 7'h19;
      4'h5:    return 7'h12;
      4'h6:    return 7'h02;
      4'h7:    return 7'h78;
      4'h8:    return 7'h00;
      4'h9:    return 7'h10;
      4'ha:    return 7'h08;
      4'hb:    return 7'h03;
      4'hc:    return 7'h46;
      4'hd:    return 7'h21;
      4'he:    return 7'h06;
      default: return 7'h0e;
    endcase
  endfunction

  always_comb
  begin
    for (int i = 0; i < 8; i++)
      hex_o[i] = nib_to_seg(seg_i[4*i +: 4]);
  end

endmodule

// File: src/interval_timer.sv
module interval_timer
  import io_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       stb_i,
  input  logic       we_i,
  input  logic [1:0] adr_i,
  input  word_t      dat_i,
  output word_t      dat_o,
  output logic       ack_o,
  output logic       irq_o
);

  word_t reload, count;
  logic  enable;

  assign ack_o = stb_i;

  always_comb
  begin
    case (adr_i)
      2'd0:    dat_o = reload;
      2'd1:    dat_o = count;
      2'd2:    dat_o = {30'h0, irq_o, enable};
      default: dat_o = '0;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      reload <= '0;
      count  <= '0;
      enable <= 1'b0;
      irq_o  <= 1'b0;
    end
    else
    begin
      if (enable)
      begin
        if (count == '0)
        begin
          count <= reload;
          irq_o <= 1'b1;  // sticky until cleared
        end
        else
          count <= count - 1'b1;
      end
      if (stb_i && we_i)
      begin
        if (adr_i == 2'd0)
        begin
          reload <= dat_i;
          count  <= dat_i;  // restart from new value
        end
        if (adr_i == 2'd2)
        begin
          enable <= dat_i[0];
          if (dat_i[1])
            irq_o <= 1'b0;  // clear wins over a set in the same cycle
        end
      end
    end
  end

endmodule

// File: src/uart_tx.sv
module uart_tx
  import io_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  byte_t head_i,
  input  logic  empty_i,
  output logic  pop_o,
  output logic  tx_o
);

  tx_state_t                         state;
  byte_t                             shift_q;
  logic [$clog2(CLKS_PER_BIT)-1:0]   baud_cnt;
  logic [2:0]                        bit_idx;
  logic                              bit_end;

  assign pop_o   = (state == TX_IDLE) && !empty_i;
  assign bit_end = (baud_cnt == ($clog2(CLKS_PER_BIT))'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state    <= TX_IDLE;
      tx_o     <= 1'b1;
      shift_q  <= '0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else
    begin
      baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
      case (state)
        TX_IDLE:
        begin
          baud_cnt <= '0;
          if (pop_o)
          begin
            shift_q <= head_i;
            tx_o    <= 1'b0;  // start bit
            state   <= TX_START;
          end
        end
        TX_START:
          if (bit_end)
          begin
            tx_o    <= shift_q[0];
            shift_q <= shift_q >> 1;
            bit_idx <= '0;
            state   <= TX_DATA;
          end
        TX_DATA:
          if (bit_end)
          begin
            if (bit_idx == 3'd7)
            begin
              tx_o  <= 1'b1;  // stop bit
              state <= TX_STOP;
            end
            else
            begin
              tx_o    <= shift_q[0];  // lsb first
              shift_q <= shift_q >> 1;
              bit_idx <= bit_idx + 1'b1;
            end
          end
        TX_STOP:
          if (bit_end)
            state <= TX_IDLE;
        default:
          state <= TX_IDLE;
      endcase
    end
  end

  idle_line_high: assert property (@(posedge clk_i) disable iff (rst_i)
                                   (state == TX_IDLE) |-> tx_o)
    else $error("tx line low while idle");

endmodule

// File: src/tx_fifo.sv
module tx_fifo
  import io_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  stb_i,
  input  logic  we_i,
  input  word_t dat_i,
  input  logic  pop_i,
  output word_t dat_o,
  output logic  ack_o,
  output byte_t head_o,
  output logic  empty_o
);

  byte_t                 mem [FIFO_DEPTH];
  logic [FIFO_CNT_W-2:0] rd_ptr, wr_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  full, push, pop;

  assign full    = (count == FIFO_CNT_W'(FIFO_DEPTH));
  assign empty_o = (count == '0);
  assign push    = stb_i && we_i && !full;  // dropped when full, still acked
  assign pop     = pop_i && !empty_o;
  assign ack_o   = stb_i;
  assign head_o  = mem[rd_ptr];
  assign dat_o   = {22'h0, full, empty_o, 4'h0, count};

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem[wr_ptr] <= dat_i[7:0];
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  count_bound: assert property (@(posedge clk_i) disable iff (rst_i)
                                count <= FIFO_CNT_W'(FIFO_DEPTH))
    else $error("fifo count above depth");

endmodule

// File: src/io_controller.sv
module io_controller
  import io_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  addr_t       adr_i,
  input  word_t       dat_i,
  input  logic [15:0] sw_i,
  input  word_t       uart_dat_i,
  input  logic        uart_ack_i,
  input  word_t       timer_dat_i,
  input  logic        timer_ack_i,
  output word_t       dat_o,
  output logic        ack_o,
  output logic        uart_stb_o,
  output logic        timer_stb_o,
  output logic [8:0]  led_o,
  output word_t       seg_o
);

  ctrl_state_t state, state_next;
  region_t     region;
  word_t       result, result_next;
  word_t       seg_next;
  logic [8:0]  led_next;

  assign region      = adr_i[13:10];
  assign ack_o       = (state == S_DONE);
  assign dat_o       = result;
  assign uart_stb_o  = (state == S_UART);
  assign timer_stb_o = (state == S_TIMER);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state  <= S_IDLE;
      result <= '0;
      led_o  <= '0;
      seg_o  <= '0;
    end
    else
    begin
      state  <= state_next;
      result <= result_next;
      led_o  <= led_next;
      seg_o  <= seg_next;
    end
  end

  always_comb
  begin
    state_next  = state;
    result_next = result;
    led_next    = led_o;
    seg_next    = seg_o;
    case (state)
      S_IDLE:
        if (cyc_i && stb_i)
        begin
          result_next = '0;                             // unmapped reads return zero
          state_next  = ctrl_state_t'({1'b0, region});  // decode by region number
        end
      S_SWLED:
      begin
        if (we_i)
          led_next = dat_i[8:0];
        else
          result_next = {16'h0000, sw_i};
        state_next = S_DONE;
      end
      S_UART:
      begin
        if (!we_i)
          result_next = uart_dat_i;
        if (uart_ack_i)
          state_next = S_DONE;
      end
      S_TIMER:
      begin
        if (!we_i)
          result_next = timer_dat_i;
        if (timer_ack_i)
          state_next = S_DONE;
      end
      S_SEG:
      begin
        if (we_i)
          seg_next = dat_i;
        else
          result_next = seg_o;
        state_next = S_DONE;
      end
      S_DONE:
        state_next = S_IDLE;
      default:
        state_next = S_DONE;  // unmapped region, no side effect
    endcase
  end

  // the master drops stb after ack, so a cycle never completes twice in a row
  ack_single: assert property (@(posedge clk_i) disable iff (rst_i) ack_o |=> !ack_o)
    else $error("ack_o high for two cycles");

endmodule

// File: src/io_pkg.sv
package io_pkg;

  typedef logic [31:0] word_t;
  typedef logic [13:0] addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [3:0]  region_t;
  typedef logic [6:0]  hex_t;    // active low, segment a in bit 0

  // address map, taken from adr[13:10]
  localparam region_t REG_SWLED = 4'd0;
  localparam region_t REG_UART  = 4'd1;
  localparam region_t REG_TIMER = 4'd2;
  localparam region_t REG_SEG   = 4'd3;

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_CNT_W = 4;   // holds 0..FIFO_DEPTH

  // short bit period keeps simulation fast
  localparam int CLKS_PER_BIT = 8;

  // region states carry the region number, so idle can jump straight there
  typedef enum logic [4:0] {
    S_SWLED = {1'b0, REG_SWLED},
    S_UART  = {1'b0, REG_UART},
    S_TIMER = {1'b0, REG_TIMER},
    S_SEG   = {1'b0, REG_SEG},
    S_IDLE  = 5'h10,
    S_DONE  = 5'h11
  } ctrl_state_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

endpackage
